// File: src/lsu_pkg.sv
// Shared types and widths for the load/store unit, imported by every RTL module that needs them
package lsu_pkg;

  ////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////

  localparam int ADDR_W = 32;                   // Byte address
  localparam int DATA_W = 32;                   // One bus word
  localparam int BE_W   = DATA_W / 8;           // One enable per byte lane
  localparam int XID_W  = 4;                    // Coprocessor instruction ID

  // Access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////

  // Core execute stage operands, address is op_a + op_b
  typedef struct packed {
    logic [ADDR_W-1:0] op_a;
    logic [ADDR_W-1:0] op_b;
    logic              we;
    lsu_size_e         size;
    logic              sext;
    logic [DATA_W-1:0] wdata;
  } core_req_t;

  // Coprocessor memory request, always word sized
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    logic [XID_W-1:0]  id;
  } xif_req_t;

  // Arbitrated request, ID only meaningful when from_xif is set
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    lsu_size_e         size;
    logic              sext;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;                      // Enables for an aligned access
    logic              from_xif;
    logic [XID_W-1:0]  id;
  } lsu_req_t;

  ////////////////////////////////////////////////////
  // Bus and writeback side
  ////////////////////////////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_resp_t;

  // Per-phase info needed when the read-valid comes back
  typedef struct packed {
    lsu_size_e         size;
    logic              sext;
    logic              we;
    logic [1:0]        offset;                  // Byte offset of the original address
    logic              last;                    // Clear only for the first phase of a split
    logic              from_xif;
    logic [XID_W-1:0]  id;
  } wb_tag_t;

  typedef struct packed {
    logic [XID_W-1:0]  id;
    logic [DATA_W-1:0] rdata;
    logic              err;
  } xif_result_t;

endpackage

// File: src/lsu_req_arbiter.sv
// Fixed-priority pick between coprocessor and core requests, instantiated once in the LSU top level
module lsu_req_arbiter import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      core_valid_i,
  input  core_req_t core_req_i,
  input  logic      xif_valid_i,
  input  xif_req_t  xif_req_i,
  input  logic      accept_i,                   // Last phase granted
  output logic      sel_valid_o,
  output lsu_req_t  sel_req_o,
  output logic      core_ready_o,
  output logic      xif_ready_o
);

  logic lock_q;                                 // A request is on the bus and not yet accepted
  logic owner_xif_q;                            // Winner held while locked
  logic pick_xif;

  // Coprocessor wins unless a core access already started
  assign pick_xif    = lock_q ? owner_xif_q : xif_valid_i;
  assign sel_valid_o = pick_xif ? xif_valid_i : core_valid_i;

  // Build the unified request
  always_comb begin
    if (pick_xif) begin
      sel_req_o.addr  = xif_req_i.addr;
      sel_req_o.we    = xif_req_i.we;
      sel_req_o.size  = SIZE_WORD;              // Coprocessor always moves a word
      sel_req_o.sext  = 1'b0;
      sel_req_o.wdata = xif_req_i.wdata;
      sel_req_o.be    = xif_req_i.be;
    end else begin
      sel_req_o.addr  = core_req_i.op_a + core_req_i.op_b;  // Address generation
      sel_req_o.we    = core_req_i.we;
      sel_req_o.size  = core_req_i.size;
      sel_req_o.sext  = core_req_i.sext;
      sel_req_o.wdata = core_req_i.wdata;
      case (core_req_i.size)
        SIZE_BYTE: sel_req_o.be = 4'b0001;
        SIZE_HALF: sel_req_o.be = 4'b0011;
        default:   sel_req_o.be = 4'b1111;
      endcase
    end
    sel_req_o.from_xif = pick_xif;
    sel_req_o.id       = xif_req_i.id;
  end

  // Lock the winner until its last phase is granted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_q      <= 1'b0;
      owner_xif_q <= 1'b0;
    end else begin
      if (accept_i) begin
        lock_q <= 1'b0;
      end else if (sel_valid_o) begin
        lock_q <= 1'b1;
      end
      if (!lock_q) owner_xif_q <= pick_xif;
    end
  end

  assign core_ready_o = accept_i && !pick_xif;
  assign xif_ready_o  = accept_i && pick_xif;

endmodule

// File: src/lsu_aligner.sv
// Turns the selected request into one or two aligned bus phases plus a writeback tag per phase
module lsu_aligner import lsu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     sel_valid_i,
  input  lsu_req_t sel_req_i,
  input  logic     phase_done_i,                // Current phase granted
  output bus_req_t bus_req_data_o,
  output logic     split_o,                     // First phase of a split in progress
  output logic     tag_valid_o,
  output wb_tag_t  tag_o,
  output logic     last_phase_o
);

  logic [1:0]          offset;
  logic                crosses;                 // Access spans two words
  logic                split_q;                 // Second phase is being issued
  logic [2*BE_W-1:0]   be_wide;                 // Enables for both words
  logic [2*DATA_W-1:0] wdata_wide;
  logic [4:0]          shamt;                   // Byte offset in bits

  assign offset = sel_req_i.addr[1:0];
  assign shamt  = {offset, 3'b000};

  ////////////////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////////////////

  always_comb begin
    case (sel_req_i.size)
      SIZE_WORD: crosses = (offset != 2'b00);
      SIZE_HALF: crosses = (offset == 2'b11);
      default:   crosses = 1'b0;               // A byte never crosses
    endcase
  end

  assign split_o      = sel_valid_i && crosses && !split_q;
  assign last_phase_o = sel_valid_i && !split_o;

  // Cleared when the request goes away so the next access starts in phase one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!sel_valid_i) begin
      split_q <= 1'b0;
    end else if (phase_done_i) begin
      split_q <= split_o;                       // Set after phase one, cleared after phase two
    end
  end

  ////////////////////////////////////////////////////
  // Byte enables and store data
  ////////////////////////////////////////////////////

  // Shift the requested enables; the upper word goes to phase two
  assign be_wide = {{BE_W{1'b0}}, sel_req_i.be} << offset;

  // Rotate left by the byte offset, upper half of the shifted pair
  assign wdata_wide = {sel_req_i.wdata, sel_req_i.wdata} << shamt;

  always_comb begin
    if (split_q) begin
      // Phase two, next word boundary
      bus_req_data_o.addr = {sel_req_i.addr[ADDR_W-1:2], 2'b00} + ADDR_W'(4);
      bus_req_data_o.be   = be_wide[2*BE_W-1:BE_W];
    end else begin
      bus_req_data_o.addr = sel_req_i.addr;
      bus_req_data_o.be   = be_wide[BE_W-1:0];
    end
    bus_req_data_o.we    = sel_req_i.we;
    bus_req_data_o.wdata = wdata_wide[2*DATA_W-1:DATA_W];
  end

  ////////////////////////////////////////////////////
  // Writeback tag
  ////////////////////////////////////////////////////

  // One tag per granted phase, queued downstream
  assign tag_valid_o = phase_done_i;

  always_comb begin
    tag_o.size     = sel_req_i.size;
    tag_o.sext     = sel_req_i.sext;
    tag_o.we       = sel_req_i.we;
    tag_o.offset   = offset;
    tag_o.last     = !split_o;                  // Only phase one of a split is not last
    tag_o.from_xif = sel_req_i.from_xif;
    tag_o.id       = sel_req_i.id;
  end

endmodule

// File: src/lsu_txn_tracker.sv
// Counts bus phases awaiting read-valid and gates new bus requests against the outstanding limit
module lsu_txn_tracker #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sel_valid_i,
  input  logic bus_gnt_i,
  input  logic bus_rvalid_i,
  output logic bus_req_o,
  output logic phase_done_o,
  output logic busy_o
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] cnt_q;                      // Granted, read-valid pending
  logic [CNT_W-1:0] cnt_d;
  logic             slot_free;

  ////////////////////////////////////////////////////
  // Request gating
  ////////////////////////////////////////////////////

  assign slot_free    = (cnt_q < CNT_W'(MAX_OUTSTANDING));
  assign bus_req_o    = sel_valid_i && slot_free;   // Combinational from valid
  assign phase_done_o = bus_req_o && bus_gnt_i;

  // Busy while requesting or with anything in flight
  assign busy_o = bus_req_o || (cnt_q != '0);

  ////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////

  always_comb begin
    case ({phase_done_o, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;            // Grant only
      2'b01:   cnt_d = cnt_q - 1'b1;            // Read-valid only
      default: cnt_d = cnt_q;                   // Neither, or both
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// File: src/lsu_rdata_align.sv
// Tag queue and read-data path: realigns, extends and routes each completed access
module lsu_rdata_align import lsu_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              tag_valid_i,
  input  wb_tag_t           tag_i,
  input  logic              bus_rvalid_i,
  input  bus_resp_t         bus_resp_i,
  output logic              core_rvalid_o,
  output logic [DATA_W-1:0] core_rdata_o,
  output logic              core_err_o,
  output logic              xif_result_valid_o,
  output xif_result_t       xif_result_o
);

  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  wb_tag_t             tag_q [MAX_OUTSTANDING];  // One entry per phase in flight
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  wb_tag_t             head;
  logic [DATA_W-1:0]   rdata_q;                 // Raw first half of a split load
  logic                err_q;                   // Error seen on the first half
  logic                is_split;
  logic [2*DATA_W-1:0] rdata_full;
  logic [DATA_W-1:0]   rdata_al;
  logic [DATA_W-1:0]   rdata_ext;
  logic                err_all;

  ////////////////////////////////////////////////////
  // Tag queue
  ////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (tag_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (bus_rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_valid_i) tag_q[wr_ptr_q] <= tag_i;
    if (bus_rvalid_i && !head.last) begin
      rdata_q <= bus_resp_i.rdata;              // Keep phase one for the join
      err_q   <= bus_resp_i.err;
    end
  end

  assign head = tag_q[rd_ptr_q];

  ////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////

  assign is_split = ((head.size == SIZE_WORD) && (head.offset != 2'b00)) ||
                    ((head.size == SIZE_HALF) && (head.offset == 2'b11));

  assign rdata_full = is_split ? {bus_resp_i.rdata, rdata_q} : {bus_resp_i.rdata, bus_resp_i.rdata};
  assign rdata_al   = DATA_W'(rdata_full >> {head.offset, 3'b000});

  always_comb begin
    case (head.size)
      SIZE_BYTE: rdata_ext = {{(DATA_W-8){head.sext && rdata_al[7]}}, rdata_al[7:0]};
      SIZE_HALF: rdata_ext = {{(DATA_W-16){head.sext && rdata_al[15]}}, rdata_al[15:0]};
      default:   rdata_ext = rdata_al;
    endcase
  end

  assign err_all = bus_resp_i.err || (is_split && err_q);  // Either half failing fails the access

  // Route by source, only on the last phase
  assign core_rvalid_o      = bus_rvalid_i && head.last && !head.from_xif;
  assign xif_result_valid_o = bus_rvalid_i && head.last && head.from_xif;
  assign core_rdata_o       = rdata_ext;
  assign core_err_o         = err_all;
  assign xif_result_o       = '{id: head.id, rdata: rdata_ext, err: err_all};

endmodule

// File: src/lsu_top.sv
// Load/store unit top level, instantiated by the processor and wired to the shared data bus
module lsu_top import lsu_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  // Core execute stage
  input  logic              core_valid_i,
  input  core_req_t         core_req_i,
  output logic              core_ready_o,
  output logic              lsu_split_o,
  output logic              core_rvalid_o,
  output logic [DATA_W-1:0] core_rdata_o,
  output logic              core_err_o,
  // Coprocessor memory port
  input  logic              xif_valid_i,
  input  xif_req_t          xif_req_i,
  output logic              xif_ready_o,
  output logic              xif_result_valid_o,
  output xif_result_t       xif_result_o,
  // Data bus
  output logic              bus_req_o,
  output bus_req_t          bus_req_data_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  bus_resp_t         bus_resp_i,
  output logic              busy_o
);

  logic     sel_valid;
  lsu_req_t sel_req;
  logic     phase_done;
  logic     last_phase;
  logic     tag_valid;
  wb_tag_t  tag;

  // Last phase of the selected access granted
  logic     accept;
  assign accept = phase_done && last_phase;

  lsu_req_arbiter u_arb (
    .clk, .rst_n,
    .core_valid_i, .core_req_i, .xif_valid_i, .xif_req_i,
    .accept_i    (accept),
    .sel_valid_o (sel_valid),
    .sel_req_o   (sel_req),
    .core_ready_o, .xif_ready_o
  );

  lsu_aligner u_align (
    .clk, .rst_n,
    .sel_valid_i  (sel_valid),
    .sel_req_i    (sel_req),
    .phase_done_i (phase_done),
    .bus_req_data_o,
    .split_o      (lsu_split_o),
    .tag_valid_o  (tag_valid),
    .tag_o        (tag),
    .last_phase_o (last_phase)
  );

  lsu_txn_tracker #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) u_trk (
    .clk, .rst_n,
    .sel_valid_i  (sel_valid),
    .bus_gnt_i, .bus_rvalid_i, .bus_req_o,
    .phase_done_o (phase_done),
    .busy_o
  );

  lsu_rdata_align #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) u_rd (
    .clk, .rst_n,
    .tag_valid_i (tag_valid),
    .tag_i       (tag),
    .bus_rvalid_i, .bus_resp_i,
    .core_rvalid_o, .core_rdata_o, .core_err_o,
    .xif_result_valid_o, .xif_result_o
  );

endmodule

// File: verif/lsu_tb_clk.sv
// Testbench clock and reset source, instantiated once by the load/store unit testbench
module lsu_tb_clk #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: verif/lsu_tb.sv
// Directed testbench for the load/store unit with a bus memory model; run as the simulation top
module lsu_tb import lsu_pkg::*; ();

  localparam int MAX_OUT = 2;                   // Outstanding limit given to the DUT
  localparam int TIMEOUT = 200;                 // Cycles allowed per wait

  logic              clk, rst_n;
  logic              core_valid_i, core_ready_o, lsu_split_o, core_rvalid_o, core_err_o;
  core_req_t         core_req_i;
  logic [DATA_W-1:0] core_rdata_o;
  logic              xif_valid_i, xif_ready_o, xif_result_valid_o;
  xif_req_t          xif_req_i;
  xif_result_t       xif_result_o;
  logic              bus_req_o, bus_gnt_i, bus_rvalid_i, busy_o;
  bus_req_t          bus_req_data_o;
  bus_resp_t         bus_resp_i;

  int                err_cnt, err_at_start, test_cnt, test_fail;
  string             cur_test;

  // Memory model state
  logic [7:0]        mem [logic [ADDR_W-1:0]];  // Written bytes only
  bus_resp_t         pend_q [$];                // Granted, read-valid pending
  int unsigned       due_q [$];
  bus_req_t          bus_log [$];               // Every granted request
  int unsigned       cycle, rsp_delay;
  bit                rand_gnt, err_en, held;
  logic [ADDR_W-1:0] err_word;
  bus_req_t          held_req;
  int                max_out;

  lsu_tb_clk #(.PERIOD(10), .RESET_CYCLES(5)) clk0 (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top #(.MAX_OUTSTANDING(MAX_OUT)) dut0 (.*);

  //////////////////////////////////////////////////
  // Reference helpers
  //////////////////////////////////////////////////

  // Unwritten bytes read back a pattern of the whole address
  function automatic logic [7:0] mem_byte(logic [ADDR_W-1:0] a);
    if (mem.exists(a)) return mem[a];
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [DATA_W-1:0] extend(logic [DATA_W-1:0] v, int nb, bit sext);
    logic [DATA_W-1:0] mask;
    mask = (nb >= 4) ? '1 : (32'h1 << (8 * nb)) - 32'h1;
    v = v & mask;
    if (sext && v[8*nb-1]) v = v | ~mask;       // Top bit of the size fills the rest
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] ref_load(logic [ADDR_W-1:0] a, int nb, bit sext);
    logic [DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < nb; i++) v[8*i +: 8] = mem_byte(a + i);  // Little endian
    return extend(v, nb, sext);
  endfunction

  function automatic logic [DATA_W-1:0] rotl_bytes(logic [DATA_W-1:0] w, int o);
    return (w << (8 * o)) | (w >> (32 - 8 * o));
  endfunction

  // Applies one granted request, read data taken at grant time
  function automatic bus_resp_t bus_access(bus_req_t r);
    bus_resp_t         rsp;
    logic [ADDR_W-1:0] wa;
    wa        = {r.addr[ADDR_W-1:2], 2'b00};
    rsp.err   = err_en && (wa == err_word);
    rsp.rdata = ref_load(wa, 4, 1'b0);
    if (r.we) begin
      for (int i = 0; i < BE_W; i++) if (r.be[i]) mem[wa + i] = r.wdata[8*i +: 8];
    end
    return rsp;
  endfunction

  //////////////////////////////////////////////////
  // Checks and reporting
  //////////////////////////////////////////////////

  task automatic report_error(string what);
    err_cnt++;
    $display("error in %s: %s", cur_test, what);
  endtask

  task automatic check_data(string what, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s %s: expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_xif(string what, xif_result_t exp, xif_result_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s %s: expected id %h data %h err %b actual id %h data %h err %b",
               cur_test, what, exp.id, exp.rdata, exp.err, act.id, act.rdata, act.err);
    end
  endtask

  task automatic check_bus(string what, bus_req_t exp, bus_req_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s %s: expected addr %h we %b be %b data %h actual addr %h we %b be %b data %h",
               cur_test, what, exp.addr, exp.we, exp.be, exp.wdata,
               act.addr, act.we, act.be, act.wdata);
    end
  endtask

  task automatic start_test(string name);
    cur_test     = name;
    err_at_start = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (err_cnt == err_at_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      test_fail++;
      $display("test %s: failed with %0d errors", cur_test, err_cnt - err_at_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      bus_gnt_i    = 1'b0;
      bus_rvalid_i = 1'b0;
    end else begin
      bus_gnt_i = rand_gnt ? ($urandom % 4 != 0) : 1'b1;  // Optional random stalls
      if (pend_q.size() != 0 && cycle >= due_q[0]) begin
        bus_rvalid_i = 1'b1;
        bus_resp_i   = pend_q[0];
      end else begin
        bus_rvalid_i = 1'b0;
        bus_resp_i   = '0;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle++;
      if (pend_q.size() != 0 && !busy_o) report_error("busy low while phases are outstanding");
      if (held) begin
        if (!bus_req_o) report_error("bus request dropped before its grant");
        else check_bus("held request", held_req, bus_req_data_o);
      end
      held     = bus_req_o && !bus_gnt_i;
      held_req = bus_req_data_o;
      if (bus_rvalid_i) begin
        void'(pend_q.pop_front());
        void'(due_q.pop_front());
      end
      if (bus_req_o && bus_gnt_i) begin
        bus_log.push_back(bus_req_data_o);
        pend_q.push_back(bus_access(bus_req_data_o));
        due_q.push_back(cycle + rsp_delay + (rand_gnt ? $urandom % 3 : 0));
        if (pend_q.size() > MAX_OUT) report_error("more grants outstanding than the limit");
        if (pend_q.size() > max_out) max_out = pend_q.size();
      end
    end
  end

  //////////////////////////////////////////////////
  // Request drivers
  //////////////////////////////////////////////////

  task automatic issue_core(bit we, lsu_size_e sz, bit sext, logic [ADDR_W-1:0] a,
                            logic [DATA_W-1:0] wd, output bit split_seen);
    int n;
    @(negedge clk);
    core_req_i.op_a  = $urandom;                // Random operand split of the address
    core_req_i.op_b  = a - core_req_i.op_a;
    core_req_i.we    = we;
    core_req_i.size  = sz;
    core_req_i.sext  = sext;
    core_req_i.wdata = wd;
    core_valid_i     = 1'b1;
    n = 0;
    @(posedge clk);
    split_seen = lsu_split_o;
    while (!core_ready_o && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!core_ready_o) report_error("core request not accepted before the timeout");
    @(negedge clk);
    core_valid_i = 1'b0;
  endtask

  task automatic issue_xif(bit we, logic [ADDR_W-1:0] a, logic [DATA_W-1:0] wd,
                           logic [BE_W-1:0] be, logic [XID_W-1:0] id);
    int n;
    @(negedge clk);
    xif_req_i   = '{addr: a, we: we, wdata: wd, be: be, id: id};
    xif_valid_i = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!xif_ready_o && n < TIMEOUT);
    if (!xif_ready_o) report_error("coprocessor request not accepted before the timeout");
    @(negedge clk);
    xif_valid_i = 1'b0;
  endtask

  task automatic wait_core_result(output logic [DATA_W-1:0] rd, output logic er);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!core_rvalid_o && n < TIMEOUT);
    if (!core_rvalid_o) report_error("no core result before the timeout");
    rd = core_rdata_o;
    er = core_err_o;
  endtask

  task automatic wait_xif_result(output xif_result_t r);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!xif_result_valid_o && n < TIMEOUT);
    if (!xif_result_valid_o) report_error("no coprocessor result before the timeout");
    r = xif_result_o;
  endtask

  task automatic core_access(bit we, lsu_size_e sz, bit sext, logic [ADDR_W-1:0] a,
                             logic [DATA_W-1:0] wd, output logic [DATA_W-1:0] rd,
                             output logic er);
    bit sp;
    issue_core(we, sz, sext, a, wd, sp);
    wait_core_result(rd, er);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic aligned_store_load();
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] wd, rd;
    logic              er;
    int                nb;
    start_test("aligned");
    rand_gnt = 1'b1;
    for (int k = 0; k < 3; k++) begin
      for (int rep = 0; rep < 4; rep++) begin
        nb = 1 << k;
        a  = 32'h1000 + ($urandom % 64) * 4 + (($urandom % 4) & ~(nb - 1));  // Size aligned
        wd = $urandom;
        core_access(1'b1, lsu_size_e'(k), 1'b0, a, wd, rd, er);
        check_flag("store error", 1'b0, er);
        core_access(1'b0, lsu_size_e'(k), 1'b0, a, '0, rd, er);
        check_data("zero extended load", extend(wd, nb, 1'b0), rd);
        core_access(1'b0, lsu_size_e'(k), 1'b1, a, '0, rd, er);
        check_data("sign extended load", extend(wd, nb, 1'b1), rd);
        check_flag("load error", 1'b0, er);
      end
    end
    rand_gnt = 1'b0;
    end_test();
  endtask

  task automatic misaligned_split();
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] wd, rd;
    logic              er;
    bit                sp;
    int                o, nb;
    bus_req_t          exp_req;
    start_test("misaligned");
    for (int k = 1; k < 5; k++) begin
      o  = (k < 4) ? k : 3;                     // Last round is a halfword at offset 3
      nb = (k < 4) ? 4 : 2;
      a  = 32'h2000 + 32'h100 * k + o;
      wd = $urandom;
      bus_log.delete();
      issue_core(1'b1, (nb == 4) ? SIZE_WORD : SIZE_HALF, 1'b0, a, wd, sp);
      wait_core_result(rd, er);
      check_flag("split flag before first grant", 1'b1, sp);
      if (bus_log.size() != 2) begin
        report_error("split store did not make two bus requests");
      end else begin
        exp_req = '{addr: a, we: 1'b1, be: '0, wdata: rotl_bytes(wd, o)};
        exp_req.be = 4'(((1 << nb) - 1) << o);  // First word lanes
        check_bus("first phase", exp_req, bus_log[0]);
        exp_req.addr = {a[ADDR_W-1:2], 2'b00} + 32'h4;
        exp_req.be   = 4'((((1 << nb) - 1) << o) >> 4);
        check_bus("second phase", exp_req, bus_log[1]);
      end
      core_access(1'b0, (nb == 4) ? SIZE_WORD : SIZE_HALF, 1'b1, a, '0, rd, er);
      check_data("load after split store", extend(wd, nb, 1'b1), rd);
      check_flag("load error", 1'b0, er);
    end
    end_test();
  endtask

  task automatic same_cycle_priority();
    logic [DATA_W-1:0] rd, exp_c;
    logic              er;
    bit                sp;
    xif_result_t       xr, exp_x;
    start_test("priority");
    exp_x = '{id: 4'h9, rdata: ref_load(32'h3000, 4, 1'b0), err: 1'b0};
    exp_c = ref_load(32'h3104, 4, 1'b0);
    bus_log.delete();
    fork
      begin
        issue_xif(1'b0, 32'h3000, '0, 4'hf, 4'h9);
        wait_xif_result(xr);
      end
      begin
        issue_core(1'b0, SIZE_WORD, 1'b0, 32'h3104, '0, sp);
        wait_core_result(rd, er);
      end
    join
    if (bus_log.size() != 2) report_error("expected two bus requests");
    else check_data("first granted address", 32'h3000, bus_log[0].addr);
    check_xif("coprocessor result", exp_x, xr);
    check_data("core load", exp_c, rd);
    end_test();
  endtask

  task automatic bus_error_report();
    logic [DATA_W-1:0] rd;
    logic              er;
    xif_result_t       xr, exp_x;
    start_test("bus error");
    err_en = 1'b1;
    for (int k = 0; k < 2; k++) begin
      err_word = k ? 32'h4000 : 32'h4004;       // Second phase, then first phase
      core_access(1'b0, SIZE_WORD, 1'b0, 32'h4001, '0, rd, er);
      check_data("split load data", ref_load(32'h4001, 4, 1'b0), rd);
      check_flag("split load error", 1'b1, er);
    end
    err_word = 32'h4200;
    exp_x    = '{id: 4'h3, rdata: ref_load(32'h4200, 4, 1'b0), err: 1'b1};
    issue_xif(1'b0, 32'h4200, '0, 4'hf, 4'h3);
    wait_xif_result(xr);
    check_xif("coprocessor load", exp_x, xr);
    err_en = 1'b0;
    core_access(1'b0, SIZE_WORD, 1'b0, 32'h4200, '0, rd, er);
    check_flag("error cleared", 1'b0, er);
    end_test();
  endtask

  task automatic outstanding_limit();
    logic [DATA_W-1:0] rd_a, rd_b, exp_a, exp_b;
    logic              er_a, er_b;
    bit                sp;
    start_test("outstanding");
    rsp_delay = 6;                              // Slow read-valids
    max_out   = 0;
    exp_a     = ref_load(32'h5001, 4, 1'b0);
    exp_b     = ref_load(32'h5010, 4, 1'b0);
    fork
      begin
        issue_core(1'b0, SIZE_WORD, 1'b0, 32'h5001, '0, sp);
        issue_core(1'b0, SIZE_WORD, 1'b0, 32'h5010, '0, sp);
      end
      begin
        wait_core_result(rd_a, er_a);
        wait_core_result(rd_b, er_b);
      end
    join
    check_data("split load", exp_a, rd_a);
    check_data("queued load", exp_b, rd_b);
    if (max_out != MAX_OUT) report_error("outstanding phases never reached the limit");
    @(posedge clk);
    check_flag("busy after last read-valid", 1'b0, busy_o);
    rsp_delay = 0;
    end_test();
  endtask

  initial begin
    int          n;
    int unsigned seed_val;
    seed_val     = $urandom(32'hd3b30138);
    core_valid_i = 1'b0;
    core_req_i   = '0;
    xif_valid_i  = 1'b0;
    xif_req_i    = '0;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_resp_i   = '0;
    rsp_delay    = 0;
    rand_gnt     = 1'b0;
    err_en       = 1'b0;
    err_word     = '0;
    n = 0;
    while (!rst_n && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    start_test("reset");
    if (!rst_n) report_error("reset never released");
    check_flag("bus_req_o", 1'b0, bus_req_o);
    check_flag("core_ready_o", 1'b0, core_ready_o);
    check_flag("xif_ready_o", 1'b0, xif_ready_o);
    check_flag("core_rvalid_o", 1'b0, core_rvalid_o);
    check_flag("xif_result_valid_o", 1'b0, xif_result_valid_o);
    check_flag("lsu_split_o", 1'b0, lsu_split_o);
    check_flag("busy_o", 1'b0, busy_o);
    end_test();
    aligned_store_load();
    misaligned_split();
    same_cycle_priority();
    bus_error_report();
    outstanding_limit();
    $display("tests %0d, tests failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
src/lsu_pkg.sv
src/lsu_req_arbiter.sv
src/lsu_aligner.sv
src/lsu_txn_tracker.sv
src/lsu_rdata_align.sv
src/lsu_top.sv
verif/lsu_tb_clk.sv
verif/lsu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and reports the outcome

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module lsu_tb \
  --Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
